// File: source/cast_fmt_pkg.sv
`default_nettype none

// Single precision and 32-bit integer format facts
package cast_fmt_pkg;

  // ------------------------------
  // Float and integer formats
  // ------------------------------
  localparam int FP_WIDTH  = 32;
  localparam int EXP_BITS  = 8;
  localparam int MAN_BITS  = 23;
  localparam int BIAS      = 127;
  localparam int INT_WIDTH = 32;

  // ------------------------------
  // Internal datapath widths
  // ------------------------------
  // Holds hidden bit plus fraction, or a whole integer
  localparam int INT_MAN_WIDTH = (MAN_BITS + 1 > INT_WIDTH) ? MAN_BITS + 1 : INT_WIDTH;
  localparam int INT_EXP_WIDTH = 10; // Signed, covers -149 up to +158
  localparam int LZC_WIDTH     = 5;  // Leading-zero count range 0..31
  localparam int TAG_WIDTH     = 4;

  // Float operand class
  typedef struct packed {
    logic is_zero;
    logic is_subnormal;
    logic is_normal;
    logic is_inf;
    logic is_nan;
    logic is_signalling; // Quiet bit clear
  } fp_info_t;

endpackage

`default_nettype wire

// File: source/cast_op_pkg.sv
`default_nettype none

// Request, response and stage payload types
package cast_op_pkg;

  import cast_fmt_pkg::*;

  typedef enum logic {
    F2I = 1'b0,
    I2F = 1'b1
  } cast_op_e;

  // RISC-V style rounding mode encoding
  typedef enum logic [2:0] {
    RNE = 3'b000, // Nearest, ties to even
    RTZ = 3'b001, // Toward zero
    RDN = 3'b010, // Toward minus infinity
    RUP = 3'b011, // Toward plus infinity
    RMM = 3'b100  // Nearest, ties away from zero
  } round_mode_e;

  typedef struct packed {
    logic nv; // Invalid
    logic dz; // Divide by zero, never raised here
    logic of; // Overflow
    logic uf; // Underflow
    logic nx; // Inexact
  } status_t;

  // ------------------------------
  // Stage payloads
  // ------------------------------
  typedef struct packed {
    logic [FP_WIDTH-1:0]  operand;     // Float bits or integer
    cast_op_e             op;
    logic                 is_unsigned; // Integer side is unsigned
    round_mode_e          rnd_mode;
    logic [TAG_WIDTH-1:0] tag;
  } cast_req_t;

  typedef struct packed {
    logic                     sign;
    logic [INT_EXP_WIDTH-1:0] exponent; // Unbiased, two's complement
    logic [INT_MAN_WIDTH-1:0] mant;     // Left-justified
    logic                     mant_is_zero;
    cast_op_e                 op;
    logic                     is_unsigned;
    round_mode_e              rnd_mode;
    fp_info_t                 info;
    logic [TAG_WIDTH-1:0]     tag;
  } norm_t;

  typedef struct packed {
    logic [FP_WIDTH-1:0]  result;
    status_t              status;
    logic [TAG_WIDTH-1:0] tag;
  } cast_resp_t;

endpackage

`default_nettype wire

// File: source/cast_pipe_reg.sv
`timescale 1ns/1ps
`default_nettype none

// One valid/ready stage, payload type chosen per instance
module cast_pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     flush_i,
  // Upstream side
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  // Downstream side
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  logic     valid_q;
  payload_t data_q;

  // Bubble popping: an empty stage always takes new data
  assign ready_o = ready_i | ~valid_q;

  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i) begin
      valid_q <= 1'b0; // Flush drops whatever is in flight
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  // Load only on a real transfer in
  always_ff @(posedge clk_i) begin
    if (ready_o && valid_i) begin
      data_q <= data_i;
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

endmodule

`default_nettype wire

// File: source/cast_normalize.sv
`timescale 1ns/1ps
`default_nettype none

// Classify, take integer magnitude, normalize and unbias
module cast_normalize
  import cast_fmt_pkg::*, cast_op_pkg::*;
(
  input  cast_req_t req_i,
  output norm_t     norm_o
);

  // ------------------------------
  // Operand fields and class
  // ------------------------------
  logic [EXP_BITS-1:0] exp_field;
  logic [MAN_BITS-1:0] man_field;
  fp_info_t            info;

  assign exp_field = req_i.operand[FP_WIDTH-2 -: EXP_BITS];
  assign man_field = req_i.operand[MAN_BITS-1:0];

  assign info.is_zero       = (exp_field == '0) && (man_field == '0);
  assign info.is_subnormal  = (exp_field == '0) && (man_field != '0);
  assign info.is_normal     = (exp_field != '0) && (exp_field != '1);
  assign info.is_inf        = (exp_field == '1) && (man_field == '0);
  assign info.is_nan        = (exp_field == '1) && (man_field != '0);
  assign info.is_signalling = info.is_nan & ~man_field[MAN_BITS-1]; // Quiet bit clear

  // ------------------------------
  // Mantissa source
  // ------------------------------
  logic                     int_sign;
  logic [INT_MAN_WIDTH-1:0] int_mag;
  logic [INT_MAN_WIDTH-1:0] fp_mant;
  logic [INT_MAN_WIDTH-1:0] encoded_mant;

  // Unsigned integers are never negative
  assign int_sign = req_i.operand[INT_WIDTH-1] & ~req_i.is_unsigned;
  assign int_mag  = int_sign ? -req_i.operand : req_i.operand;
  // Hidden bit only for normals, zero padded at the top
  assign fp_mant  = {{(INT_MAN_WIDTH-MAN_BITS-1){1'b0}}, info.is_normal, man_field};

  assign encoded_mant = (req_i.op == I2F) ? int_mag : fp_mant;

  // Leading-zero count
  logic [LZC_WIDTH-1:0] lz_cnt;
  logic                 lz_found;

  always_comb begin
    lz_cnt   = '0;
    lz_found = 1'b0;
    for (int i = INT_MAN_WIDTH - 1; i >= 0; i--) begin
      if (!lz_found && encoded_mant[i]) begin
        lz_cnt   = LZC_WIDTH'(INT_MAN_WIDTH - 1 - i); // First one from the top
        lz_found = 1'b1;
      end
    end
  end

  // ------------------------------
  // Exponent
  // ------------------------------
  logic [INT_EXP_WIDTH-1:0] fp_exp;
  logic [INT_EXP_WIDTH-1:0] int_exp;

  // Biased exp, subnormal fix, unbias, undo shift, offset of narrow fraction
  assign fp_exp = INT_EXP_WIDTH'(exp_field) + INT_EXP_WIDTH'(info.is_subnormal)
                - INT_EXP_WIDTH'(BIAS) - INT_EXP_WIDTH'(lz_cnt)
                + INT_EXP_WIDTH'(INT_MAN_WIDTH - 1 - MAN_BITS);
  assign int_exp = INT_EXP_WIDTH'(INT_MAN_WIDTH - 1) - INT_EXP_WIDTH'(lz_cnt);

  assign norm_o.sign         = (req_i.op == I2F) ? int_sign : req_i.operand[FP_WIDTH-1];
  assign norm_o.exponent     = (req_i.op == I2F) ? int_exp : fp_exp;
  assign norm_o.mant         = encoded_mant << lz_cnt; // Left-justify
  assign norm_o.mant_is_zero = ~lz_found;              // Integer zero or float zero
  assign norm_o.op           = req_i.op;
  assign norm_o.is_unsigned  = req_i.is_unsigned;
  assign norm_o.rnd_mode     = req_i.rnd_mode;
  assign norm_o.info         = info;
  assign norm_o.tag          = req_i.tag;

endmodule

`default_nettype wire

// File: source/cast_shift_round.sv
`timescale 1ns/1ps
`default_nettype none

// Range check, alignment shift, round/sticky extraction, rounding
module cast_shift_round
  import cast_fmt_pkg::*, cast_op_pkg::*;
(
  input  norm_t                norm_i,
  output logic [INT_WIDTH-1:0] rounded_abs_o,
  output logic                 rounded_sign_o,
  output logic                 of_before_o,
  output logic                 of_after_o,
  output logic                 uf_after_o,
  output logic [1:0]           round_sticky_o
);

  logic signed [INT_EXP_WIDTH-1:0] in_exp;
  logic signed [INT_EXP_WIDTH-1:0] dst_exp;   // Rebiased for I2F
  logic signed [INT_EXP_WIDTH-1:0] int_limit; // Unsigned range is one bit wider

  assign in_exp    = norm_i.exponent;
  assign dst_exp   = in_exp + $signed(INT_EXP_WIDTH'(BIAS));
  assign int_limit = INT_EXP_WIDTH'(INT_WIDTH - 1 + int'(norm_i.is_unsigned));

  // ------------------------------
  // Alignment
  // ------------------------------
  logic [2*INT_MAN_WIDTH:0] preshift_mant;
  logic [2*INT_MAN_WIDTH:0] shifted_mant;
  logic [LZC_WIDTH:0]       shamt;  // Up to INT_WIDTH + 1
  logic [EXP_BITS-1:0]      fp_exp;

  always_comb begin
    shamt         = '0;
    fp_exp        = dst_exp[EXP_BITS-1:0];
    preshift_mant = {norm_i.mant, {(INT_MAN_WIDTH+1){1'b0}}}; // Mantissa at the top
    of_before_o   = 1'b0;
    if (norm_i.op == F2I) begin
      shamt = (LZC_WIDTH+1)'(INT_WIDTH - 1 - in_exp); // Integer LSB above round bit
      if (in_exp >= int_limit) begin
        shamt       = '0;
        of_before_o = 1'b1;
      end else if (in_exp < $signed(INT_EXP_WIDTH'(-1))) begin
        shamt = (LZC_WIDTH+1)'(INT_WIDTH + 1); // Everything lands in sticky
      end
    end else if (dst_exp >= $signed(INT_EXP_WIDTH'(2**EXP_BITS - 1))) begin
      fp_exp        = EXP_BITS'(2**EXP_BITS - 2); // Largest normal
      preshift_mant = '1;                         // with round and sticky set
      of_before_o   = 1'b1;
    end
  end

  assign shifted_mant = preshift_mant >> shamt;

  // ------------------------------
  // Round and sticky bits
  // ------------------------------
  logic [INT_WIDTH-1:0] final_int;
  logic [MAN_BITS-1:0]  final_man;  // Hidden bit dropped
  logic [1:0]           int_rs;
  logic [1:0]           fp_rs;
  logic [INT_WIDTH-1:0] pre_round_abs;

  assign final_int = shifted_mant[2*INT_MAN_WIDTH -: INT_WIDTH];
  assign int_rs[1] = shifted_mant[2*INT_MAN_WIDTH-INT_WIDTH];
  assign int_rs[0] = |shifted_mant[2*INT_MAN_WIDTH-INT_WIDTH-1:0];

  assign final_man = shifted_mant[2*INT_MAN_WIDTH-1 -: MAN_BITS];
  assign fp_rs[1]  = shifted_mant[2*INT_MAN_WIDTH-1-MAN_BITS];
  assign fp_rs[0]  = |shifted_mant[2*INT_MAN_WIDTH-2-MAN_BITS:0];

  assign round_sticky_o = (norm_i.op == F2I) ? int_rs : fp_rs;
  assign pre_round_abs  = (norm_i.op == F2I) ? final_int : {1'b0, fp_exp, final_man};

  // ------------------------------
  // Rounding
  // ------------------------------
  logic round_up;

  always_comb begin
    unique case (norm_i.rnd_mode)
      RNE:     round_up = round_sticky_o[1] & (round_sticky_o[0] | pre_round_abs[0]);
      RTZ:     round_up = 1'b0;
      RDN:     round_up = (|round_sticky_o) & norm_i.sign;
      RUP:     round_up = (|round_sticky_o) & ~norm_i.sign;
      RMM:     round_up = round_sticky_o[1]; // Ties away
      default: round_up = 1'b0;
    endcase
  end

  assign rounded_abs_o  = pre_round_abs + INT_WIDTH'(round_up); // Carry may bump exponent
  assign rounded_sign_o = norm_i.sign;

  // Float classification after rounding
  assign of_after_o = (rounded_abs_o[MAN_BITS +: EXP_BITS] == '1);
  assign uf_after_o = (rounded_abs_o[MAN_BITS +: EXP_BITS] == '0);

endmodule

`default_nettype wire

// File: source/cast_finalize.sv
`timescale 1ns/1ps
`default_nettype none

// Special cases, status flags and result selection
module cast_finalize
  import cast_fmt_pkg::*, cast_op_pkg::*;
(
  input  norm_t                norm_i,
  input  logic [INT_WIDTH-1:0] rounded_abs_i,
  input  logic                 rounded_sign_i,
  input  logic                 of_before_i,
  input  logic                 of_after_i,
  input  logic                 uf_after_i,
  input  logic [1:0]           round_sticky_i,
  output cast_resp_t           resp_o
);

  // ------------------------------
  // Integer result
  // ------------------------------
  logic [INT_WIDTH-1:0] rounded_int;
  logic [INT_WIDTH-1:0] int_special_res;
  logic                 int_is_special;
  logic [INT_WIDTH-1:0] int_result;
  status_t              int_status;

  // Two's complement for negative values
  assign rounded_int = rounded_sign_i ? -rounded_abs_i : rounded_abs_i;

  // NaN, inf, out of range, or negative nonzero into unsigned
  assign int_is_special = norm_i.info.is_nan | norm_i.info.is_inf | of_before_i
                        | (rounded_sign_i & norm_i.is_unsigned & (rounded_int != '0));

  always_comb begin
    int_special_res = {norm_i.is_unsigned, {(INT_WIDTH-1){1'b1}}}; // Positive max
    if (rounded_sign_i && !norm_i.info.is_nan) begin
      int_special_res = ~int_special_res; // Negative max, or 0 when unsigned
    end
    int_status = '0;
    if (int_is_special) begin
      int_result    = int_special_res;
      int_status.nv = 1'b1; // Every saturated case is invalid
    end else begin
      int_result    = rounded_int;
      int_status.nx = |round_sticky_i;
    end
  end

  // ------------------------------
  // Float result
  // ------------------------------
  logic [FP_WIDTH-1:0] fp_result;
  status_t             fp_status;

  // Integer zero gives +0
  assign fp_result = norm_i.mant_is_zero ? '0
                                         : {rounded_sign_i, rounded_abs_i[FP_WIDTH-2:0]};

  always_comb begin
    fp_status    = '0;
    fp_status.nx = |round_sticky_i;
    fp_status.nv = of_before_i | of_after_i; // Integer source out of float range
    fp_status.uf = uf_after_i & fp_status.nx;
  end

  assign resp_o.result = (norm_i.op == F2I) ? int_result : fp_result;
  assign resp_o.status = (norm_i.op == F2I) ? int_status : fp_status;
  assign resp_o.tag    = norm_i.tag;

endmodule

`default_nettype wire

// File: source/fp_int_cast.sv
`timescale 1ns/1ps
`default_nettype none

// Three-stage float/integer converter
module fp_int_cast
  import cast_op_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       flush_i,
  input  cast_req_t  req_i,
  input  logic       in_valid_i,
  output logic       in_ready_o,
  output cast_resp_t resp_o,
  output logic       out_valid_o,
  input  logic       out_ready_i,
  output logic       busy_o
);

  cast_req_t  req_q;
  logic       req_valid;
  norm_t      norm_d;
  norm_t      norm_q;
  logic       norm_valid;
  logic       norm_ready;  // Ready into middle stage
  logic       resp_ready;  // Ready into output stage
  cast_resp_t resp_d;

  logic [31:0] rounded_abs;
  logic        rounded_sign;
  logic        of_before;
  logic        of_after;
  logic        uf_after;
  logic [1:0]  round_sticky;

  // ------------------------------
  // Input stage and normalization
  // ------------------------------
  cast_pipe_reg #(.payload_t(cast_req_t)) u_in_reg (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .flush_i (flush_i),
    .valid_i (in_valid_i),
    .ready_o (in_ready_o),
    .data_i  (req_i),
    .valid_o (req_valid),
    .ready_i (norm_ready),
    .data_o  (req_q)
  );

  cast_normalize u_normalize (
    .req_i  (req_q),
    .norm_o (norm_d)
  );

  // ------------------------------
  // Middle stage, shift and round
  // ------------------------------
  cast_pipe_reg #(.payload_t(norm_t)) u_mid_reg (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .flush_i (flush_i),
    .valid_i (req_valid),
    .ready_o (norm_ready),
    .data_i  (norm_d),
    .valid_o (norm_valid),
    .ready_i (resp_ready),
    .data_o  (norm_q)
  );

  cast_shift_round u_shift_round (
    .norm_i         (norm_q),
    .rounded_abs_o  (rounded_abs),
    .rounded_sign_o (rounded_sign),
    .of_before_o    (of_before),
    .of_after_o     (of_after),
    .uf_after_o     (uf_after),
    .round_sticky_o (round_sticky)
  );

  cast_finalize u_finalize (
    .norm_i         (norm_q),
    .rounded_abs_i  (rounded_abs),
    .rounded_sign_i (rounded_sign),
    .of_before_i    (of_before),
    .of_after_i     (of_after),
    .uf_after_i     (uf_after),
    .round_sticky_i (round_sticky),
    .resp_o         (resp_d)
  );

  // Output stage, ready comes straight from the consumer
  cast_pipe_reg #(.payload_t(cast_resp_t)) u_out_reg (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .flush_i (flush_i),
    .valid_i (norm_valid),
    .ready_o (resp_ready),
    .data_i  (resp_d),
    .valid_o (out_valid_o),
    .ready_i (out_ready_i),
    .data_o  (resp_o)
  );

  assign busy_o = req_valid | norm_valid | out_valid_o; // Anything in flight

endmodule

`default_nettype wire

// File: sim/cast_model.svh
`ifndef CAST_MODEL_SVH
`define CAST_MODEL_SVH

// Rounding decision on a magnitude, lsb is the last kept bit
function automatic bit round_incr(round_mode_e rm, bit sign, bit lsb, bit rnd, bit stk);
  case (rm)
    RNE:     return rnd & (stk | lsb);
    RTZ:     return 1'b0;
    RDN:     return (rnd | stk) & sign;
    RUP:     return (rnd | stk) & ~sign;
    RMM:     return rnd; // Ties away from zero
    default: return 1'b0;
  endcase
endfunction

// Integer to single precision
function automatic cast_resp_t model_i2f(logic [31:0] val, bit uns, round_mode_e rm);
  cast_resp_t  r;
  bit          sign;
  logic [31:0] mag;
  logic [31:0] kept;
  logic [31:0] lost;
  int          msb;
  int          sh;
  bit          rnd;
  bit          stk;
  r    = '0;
  sign = val[31] & ~uns;
  mag  = sign ? -val : val;
  if (mag == 0) begin
    return r; // Plus zero, exact
  end
  msb = 31;
  while (!mag[msb]) begin
    msb--;
  end
  rnd = 1'b0;
  stk = 1'b0;
  if (msb <= 23) begin
    kept = mag << (23 - msb); // Fits the 24-bit significand
  end else begin
    sh   = msb - 23;
    kept = mag >> sh;
    lost = mag & ((32'd1 << sh) - 1);
    rnd  = lost[sh-1];
    stk  = (lost & ((32'd1 << (sh - 1)) - 1)) != 0;
  end
  kept = kept + 32'(round_incr(rm, sign, kept[0], rnd, stk));
  if (kept[24]) begin
    kept = kept >> 1; // Carry into the next binade
    msb++;
  end
  r.result    = {sign, 8'(127 + msb), kept[22:0]};
  r.status.nx = rnd | stk;
  return r;
endfunction

// Single precision to integer, range taken from the exponent before rounding
function automatic cast_resp_t model_f2i(logic [31:0] f, bit uns, round_mode_e rm);
  cast_resp_t  r;
  bit          sign;
  bit          special;
  bit          rnd;
  bit          stk;
  int          e;
  int          ex;
  int          sh;
  logic [23:0] sig;
  logic [31:0] ip;
  logic [31:0] res;
  r       = '0;
  sign    = f[31];
  e       = int'(f[30:23]);
  special = 1'b0;
  ip      = '0;
  res     = '0;
  rnd     = 1'b0;
  stk     = 1'b0;
  if (e == 255) begin
    special = 1'b1; // NaN or infinity
  end else if (e == 0) begin
    stk = (f[22:0] != 0); // Zero or subnormal, far below one half
  end else begin
    ex  = e - 127;
    sig = {1'b1, f[22:0]};
    if (ex >= 31 + int'(uns)) begin
      special = 1'b1;
    end else if (ex < -1) begin
      stk = 1'b1;
    end else if (ex >= 23) begin
      ip = 32'(sig) << (ex - 23);
    end else begin
      sh  = 23 - ex;
      ip  = 32'(sig >> sh);
      rnd = sig[sh-1];
      stk = (sig & ((24'd1 << (sh - 1)) - 1)) != 0;
    end
  end
  if (!special) begin
    ip  = ip + 32'(round_incr(rm, sign, ip[0], rnd, stk));
    res = sign ? -ip : ip;
    if (sign && uns && res != 0) begin
      special = 1'b1; // Negative into unsigned
    end
  end
  if (special) begin
    r.result = uns ? 32'hFFFF_FFFF : 32'h7FFF_FFFF;
    if (sign && !(e == 255 && f[22:0] != 0)) begin
      r.result = ~r.result;
    end
    r.status.nv = 1'b1;
  end else begin
    r.result    = res;
    r.status.nx = rnd | stk;
  end
  return r;
endfunction

`endif

// File: sim/tb_fp_int_cast.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fp_int_cast
  import cast_fmt_pkg::*, cast_op_pkg::*;
();

  localparam int CLK_PERIOD   = 8;
  localparam int N_I2F        = 400;
  localparam int N_F2I        = 400;
  localparam int N_SPEC       = 100;
  localparam int N_LAT        = 50;
  localparam int N_BP         = 200;
  localparam int N_FLUSH      = 40;
  localparam int TOTAL_OPS    = N_I2F + N_F2I + N_SPEC + N_LAT + N_BP + N_FLUSH;
  localparam int DRAIN_CYCLES = 100; // Generous bound for three items under random ready

  logic       clk_i;
  logic       reset_i;
  logic       flush_i;
  cast_req_t  req_i;
  logic       in_valid_i;
  logic       in_ready_o;
  cast_resp_t resp_o;
  logic       out_valid_o;
  logic       out_ready_i;
  logic       busy_o;

  `include "cast_model.svh"

  // Scoreboard state
  cast_resp_t exp_q[$];
  int         acc_q[$];    // Cycle of each request handshake
  int         cyc;
  int         errors;
  int         test_errors;
  int         tests_run;
  int         checked;
  int         ready_mode;  // 0 high, 1 random, 2 low
  bit         lat_check;
  logic [3:0] tag_ctr;

  fp_int_cast dut_i (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .flush_i     (flush_i),
    .req_i       (req_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .resp_o      (resp_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .busy_o      (busy_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cyc = cyc + 1;
  end

  // Consumer ready changes just after the edge
  always @(posedge clk_i) begin
    #1;
    case (ready_mode)
      0:       out_ready_i = 1'b1;
      1:       out_ready_i = 1'($urandom_range(0, 1));
      default: out_ready_i = 1'b0;
    endcase
  end

  // Watchdog
  initial begin
    #(TOTAL_OPS * 20 * CLK_PERIOD);
    $display("Timeout: the run did not finish within %0d cycles", TOTAL_OPS * 20);
    $display("Simulation finished: FAIL");
    $finish;
  end

  task automatic note_error();
    errors++;
    test_errors++;
  endtask

  function automatic cast_resp_t expect_for(cast_req_t r);
    cast_resp_t e;
    if (r.op == I2F) begin
      e = model_i2f(r.operand, r.is_unsigned, r.rnd_mode);
    end else begin
      e = model_f2i(r.operand, r.is_unsigned, r.rnd_mode);
    end
    e.tag = r.tag;
    return e;
  endfunction

  task automatic check_response();
    cast_resp_t want;
    int         lat;
    assert (exp_q.size() != 0) else begin
      $display("Extra response with tag %0h at %0t, nothing was outstanding", resp_o.tag, $time);
      note_error();
    end
    if (exp_q.size() != 0) begin
      want = exp_q.pop_front();
      lat  = cyc - acc_q.pop_front(); // Request cycle to response cycle
      checked++;
      assert (resp_o == want) else begin
        $display("mismatch at %0t: tag %0h expected %08h/%05b, got tag %0h %08h/%05b",
                 $time, want.tag, want.result, want.status, resp_o.tag, resp_o.result,
                 resp_o.status);
        note_error();
      end
      if (lat_check) begin
        assert (lat == 3) else begin
          $display("mismatch at %0t: tag %0h latency 3 expected, got %0d", $time, want.tag, lat);
          note_error();
        end
      end
    end
  endtask

  // Monitor samples at the falling edge where everything is settled
  always @(negedge clk_i) begin
    if (!reset_i) begin
      if (flush_i) begin
        exp_q.delete(); // Everything in flight is gone
        acc_q.delete();
      end else begin
        if (out_valid_o && out_ready_i) begin
          check_response();
        end
        if (in_valid_i && in_ready_o) begin
          exp_q.push_back(expect_for(req_i));
          acc_q.push_back(cyc);
        end
      end
    end
  end

  // ------------------------------
  // Stimulus helpers
  // ------------------------------
  function automatic cast_req_t build_req(cast_op_e op, logic [31:0] operand);
    cast_req_t r;
    r.operand     = operand;
    r.op          = op;
    r.is_unsigned = 1'($urandom_range(0, 1));
    r.rnd_mode    = round_mode_e'($urandom_range(0, 4));
    r.tag         = tag_ctr;
    return r;
  endfunction

  function automatic logic [31:0] random_float(int e_lo, int e_hi);
    return {1'($urandom_range(0, 1)), 8'($urandom_range(e_lo, e_hi)), 23'($urandom)};
  endfunction

  function automatic cast_req_t pick_req(int kind);
    logic [31:0] v;
    int          sel;
    sel = $urandom_range(0, 4);
    case (kind)
      0: begin
        v = $urandom;
        if (sel == 0) v = '0;              // Zero
        if (sel == 1) v = v >> $urandom_range(0, 31); // Small magnitudes
        return build_req(I2F, v);
      end
      1: begin
        v = random_float(100, 157);        // Magnitude below 2^31
        if (sel == 0) v = random_float(158, 158);
        return build_req(F2I, v);
      end
      default: begin
        case (sel)
          0:       v = {1'($urandom_range(0, 1)), 8'hFF, 23'($urandom) | 23'd1}; // NaN
          1:       v = {1'($urandom_range(0, 1)), 8'hFF, 23'd0};                 // Infinity
          2:       v = random_float(158, 254);                                   // Too large
          3:       v = {1'b1, 8'($urandom_range(120, 157)), 23'($urandom)};       // Negative
          default: v = {1'($urandom_range(0, 1)), 8'd0, 23'($urandom_range(0, 15))};
        endcase
        return build_req(F2I, v);
      end
    endcase
  endfunction

  // Called just after a rising edge and returns just after the accepting edge
  task automatic send_req(cast_req_t r);
    bit took;
    took       = 1'b0;
    req_i      = r;
    in_valid_i = 1'b1;
    while (!took) begin
      @(negedge clk_i);
      took = in_ready_o;
      @(posedge clk_i);
      #1;
    end
    in_valid_i = 1'b0;
    tag_ctr    = tag_ctr + 1'b1;
  endtask

  task automatic run_ops(int kind, int count, bit gaps);
    int k;
    for (int i = 0; i < count; i++) begin
      k = (kind < 0) ? $urandom_range(0, 2) : kind;
      send_req(pick_req(k));
      if (gaps && $urandom_range(0, 3) == 0) begin
        @(posedge clk_i);
        #1;
      end
    end
  endtask

  // Bounded wait for every outstanding response
  task automatic wait_drain();
    int waited;
    waited = 0;
    while ((exp_q.size() != 0 || busy_o) && waited < DRAIN_CYCLES) begin
      @(posedge clk_i);
      #1;
      waited++;
    end
    assert (exp_q.size() == 0 && !busy_o) else begin
      $display("Pipeline did not drain, %0d responses never arrived, busy %b", exp_q.size(),
               busy_o);
      note_error();
      exp_q.delete();
      acc_q.delete();
    end
  endtask

  task automatic end_test(string name);
    tests_run++;
    $display("test %-14s %s (%0d errors)", name, (test_errors == 0) ? "ok" : "FAILED",
             test_errors);
    test_errors = 0;
  endtask

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial begin
    void'($urandom(87463));
    cyc = 0;
    errors = 0;
    test_errors = 0;
    tests_run = 0;
    checked = 0;
    ready_mode = 0;
    lat_check = 1'b0;
    tag_ctr = '0;
    reset_i = 1'b1;
    flush_i = 1'b0;
    req_i = '0;
    in_valid_i = 1'b0;
    out_ready_i = 1'b1;
    repeat (5) @(posedge clk_i);
    #1;
    reset_i = 1'b0;

    @(negedge clk_i);
    assert (!out_valid_o && !busy_o && in_ready_o) else begin
      $display("mismatch at %0t: after reset out_valid %b busy %b in_ready %b", $time,
               out_valid_o, busy_o, in_ready_o);
      note_error();
    end
    @(posedge clk_i);
    #1;
    end_test("reset");

    run_ops(0, N_I2F, 1'b0);
    wait_drain();
    end_test("i2f");
    run_ops(1, N_F2I, 1'b0);
    wait_drain();
    end_test("f2i_range");
    run_ops(2, N_SPEC, 1'b0);
    wait_drain();
    end_test("f2i_special");

    lat_check = 1'b1;
    run_ops(-1, N_LAT, 1'b1);
    wait_drain();
    lat_check = 1'b0;
    end_test("latency");

    ready_mode = 1;
    run_ops(-1, N_BP, 1'b1);
    wait_drain();
    end_test("backpressure");

    // Park two items in the middle and output stages, then flush with a request on offer
    ready_mode = 2;
    repeat (2) @(posedge clk_i);
    #1;
    run_ops(-1, 2, 1'b0);
    @(posedge clk_i); // Both move on, input stage empties and stays ready
    #1;
    req_i      = pick_req(0);
    in_valid_i = 1'b1;
    flush_i    = 1'b1;
    @(posedge clk_i);
    #1;
    flush_i    = 1'b0;
    in_valid_i = 1'b0;
    @(negedge clk_i);
    assert (!busy_o && !out_valid_o) else begin
      $display("Flush left items in flight, busy %b out_valid %b", busy_o, out_valid_o);
      note_error();
    end
    ready_mode = 0;
    repeat (6) @(posedge clk_i); // Any response now counts as extra
    #1;
    run_ops(-1, N_FLUSH - 3, 1'b1);
    wait_drain();
    end_test("flush");

    $display("%0d tests, %0d responses checked, %0d errors", tests_run, checked, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
+incdir+sim
source/cast_fmt_pkg.sv
source/cast_op_pkg.sv
source/cast_pipe_reg.sv
source/cast_normalize.sv
source/cast_shift_round.sv
source/cast_finalize.sv
source/fp_int_cast.sv
sim/tb_fp_int_cast.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the converter testbench with Verilator
rm -f sim.log
verilator --binary -j 0 --top-module tb_fp_int_cast -f all.f \
  && ./obj_dir/Vtb_fp_int_cast > sim.log 2>&1 \
  || echo "Simulation finished: FAIL" >> sim.log
cat sim.log
grep -q "Simulation finished: FAIL" sim.log && exit 1 || exit 0
